//--- all.f
+incdir+source
source/csr_pkg.sv
source/retire_counters.sv
source/csr_regfile.sv
source/elastic_buffer.sv
source/csr_exec.sv
source/csr_top.sv
verif/csr_tb.sv

//--- verif/csr_input.txt
# op addr wid pid use_imm imm5 rs1_lane0..3 expected_lane0..3 check (op: 0 rw, 1 rs, 2 rc)
# All fields in hex. check 1 compares exactly, check 0 marks a cycle or instret read
0 340 0 0 0 00 deadbeef deadbeef deadbeef deadbeef 00000000 00000000 00000000 00000000 1
0 340 1 1 0 00 12345678 12345678 12345678 12345678 00000000 00000000 00000000 00000000 1
1 340 0 0 0 00 0000ffff 11111111 22222222 33333333 deadbeef deadbeef deadbeef deadbeef 1
2 340 1 1 0 00 000000ff 000000ff 000000ff 000000ff 12345678 12345678 12345678 12345678 1
1 340 0 0 1 00 ffffffff ffffffff ffffffff ffffffff deadffff deadffff deadffff deadffff 1
2 340 0 1 1 00 ffffffff ffffffff ffffffff ffffffff deadffff deadffff deadffff deadffff 1
1 340 1 0 1 1f 00000000 00000000 00000000 00000000 12345600 12345600 12345600 12345600 1
2 340 1 0 1 10 00000000 00000000 00000000 00000000 1234561f 1234561f 1234561f 1234561f 1
0 340 0 0 0 00 00000000 00000000 00000000 00000000 deadffff deadffff deadffff deadffff 1
1 340 1 0 1 00 00000000 00000000 00000000 00000000 1234560f 1234560f 1234560f 1234560f 1
1 340 0 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
0 003 2 0 0 00 ffffffe5 ffffffe5 ffffffe5 ffffffe5 00000000 00000000 00000000 00000000 1
1 001 2 0 1 00 00000000 00000000 00000000 00000000 00000005 00000005 00000005 00000005 1
1 002 2 0 1 00 00000000 00000000 00000000 00000000 00000007 00000007 00000007 00000007 1
0 002 2 0 1 03 ffffffff ffffffff ffffffff ffffffff 00000007 00000007 00000007 00000007 1
1 001 2 0 1 00 00000000 00000000 00000000 00000000 00000005 00000005 00000005 00000005 1
1 003 2 0 1 00 00000000 00000000 00000000 00000000 00000065 00000065 00000065 00000065 1
2 001 2 0 1 01 00000000 00000000 00000000 00000000 00000005 00000005 00000005 00000005 1
1 003 2 1 1 00 00000000 00000000 00000000 00000000 00000064 00000064 00000064 00000064 1
1 003 3 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
1 cc0 3 1 1 00 00000000 00000000 00000000 00000000 00000004 00000005 00000006 00000007 1
0 cc0 0 0 0 00 deadbeef deadbeef deadbeef deadbeef 00000000 00000001 00000002 00000003 1
1 f14 3 1 1 00 00000000 00000000 00000000 00000000 0000005c 0000005d 0000005e 0000005f 1
1 f14 1 0 1 00 00000000 00000000 00000000 00000000 00000048 00000049 0000004a 0000004b 1
0 7c0 0 0 0 00 aaaa5555 aaaa5555 aaaa5555 aaaa5555 00000000 00000000 00000000 00000000 1
1 7c0 0 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1
1 c00 0 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
1 c00 1 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
0 c02 1 0 0 00 ffffffff ffffffff ffffffff ffffffff 00000000 00000000 00000000 00000000 0
1 c02 0 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
1 340 1 1 1 00 00000000 00000000 00000000 00000000 1234560f 1234560f 1234560f 1234560f 1
1 340 0 0 1 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 1

//--- verif/csr_tb.sv
/*
 * Self-checking testbench for the CSR block. Requests and expected old
 * values come from verif/csr_input.txt; results are taken under random
 * back-pressure and compared in order of acceptance.
 */
`include "csr_cfg.svh"

module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int ACCEPT_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT  = 200;

    // A result still owed by the DUT and the retire count at its acceptance
    typedef struct packed {
        csr_rsp_t    rsp;
        logic [11:0] addr;
        logic        chk;
        logic [31:0] delivered;
        logic [15:0] index;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    csr_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    csr_rsp_t    rsp;
    logic        rsp_ready;

    expect_t     exp_q[$];
    int          errors = 0;
    int          delivered = 0;
    logic [31:0] last_cycle = '0;
    logic [15:0] lfsr = 16'd78;
    logic        done = 1'b0;

    csr_top #(
        .CORE_ID (2)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic void report_mismatch(input string what, input logic [31:0] exp_val,
                                            input logic [31:0] got_val);
        $display("mismatch at %0d ns: %s expected %h got %h", $time, what, exp_val, got_val);
        errors++;
    endfunction

    function automatic bit parse_vector(input string line, input int index,
                                        output csr_req_t r, output expect_t e);
        logic [31:0] f [15];
        int          n;
        r = '0;
        e = '0;
        if (line.len() == 0 || line.getc(0) == "#") begin
            return 1'b0;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (n <= 0) begin
            return 1'b0;
        end
        if (n != 15) begin
            $display("vector line after vector %0d is malformed, %0d fields read", index, n);
            errors++;
            return 1'b0;
        end
        r.op      = csr_op_e'(f[0][1:0]);
        r.addr    = f[1][11:0];
        r.wid     = f[2][`WID_BITS-1:0];
        r.pid     = f[3][`PID_BITS-1:0];
        r.use_imm = f[4][0];
        r.imm5    = f[5][4:0];
        for (int i = 0; i < `NUM_LANES; i++) begin
            r.rs1[i]      = f[6 + i];
            e.rsp.data[i] = f[10 + i];
        end
        e.rsp.wid = r.wid;
        e.rsp.pid = r.pid;
        e.addr    = r.addr;
        e.chk     = f[14][0];
        e.index   = 16'(index);
        return 1'b1;
    endfunction

    function automatic void check_response(input expect_t e, input csr_rsp_t got);
        assert (got.wid == e.rsp.wid) else begin
            report_mismatch($sformatf("rsp.wid of vector %0d", e.index), e.rsp.wid, got.wid);
        end
        assert (got.pid == e.rsp.pid) else begin
            report_mismatch($sformatf("rsp.pid of vector %0d", e.index), e.rsp.pid, got.pid);
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (e.chk) begin
                assert (got.data[i] == e.rsp.data[i]) else begin
                    report_mismatch($sformatf("rsp.data[%0d] of vector %0d", i, e.index),
                                    e.rsp.data[i], got.data[i]);
                end
            end else if (e.addr == `CSR_CYCLE) begin
                // Cycle reads only have to move forward
                assert (got.data[i] > last_cycle) else begin
                    report_mismatch($sformatf("rsp.data[%0d] of vector %0d above", i, e.index),
                                    last_cycle, got.data[i]);
                end
            end else begin
                assert (got.data[i] >= e.delivered) else begin
                    report_mismatch($sformatf("rsp.data[%0d] of vector %0d at least", i, e.index),
                                    e.delivered, got.data[i]);
                end
            end
        end
        if (!e.chk && e.addr == `CSR_CYCLE) begin
            last_cycle = got.data[0];
        end
    endfunction

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic send_request(input csr_req_t r, input expect_t e, output logic ok);
        int waited;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready && waited < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = req_ready;
        if (ok) begin
            e.delivered = 32'(delivered);
            exp_q.push_back(e);
            @(negedge clk);
        end else begin
            $display("timeout: vector %0d not accepted within %0d cycles",
                     e.index, ACCEPT_TIMEOUT);
            errors++;
        end
    endtask

    // Applies random back-pressure and checks each result in the cycle it is taken
    initial begin : rsp_monitor
        logic    took;
        logic    first_bit;
        expect_t e;
        rsp_ready = 1'b0;
        while (!done) begin
            @(negedge clk);
            lfsr      = lfsr_next(lfsr);
            first_bit = lfsr[0];
            lfsr      = lfsr_next(lfsr);
            rsp_ready = first_bit | lfsr[0];
            took      = rsp_valid && rsp_ready;
            if (took) begin
                assert (exp_q.size() > 0) else begin
                    $display("result at %0d ns arrived with no request outstanding", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    check_response(e, rsp);
                end
            end
            @(posedge clk);
            if (took) begin
                delivered++;
            end
        end
    end

    initial begin : stimulus
        csr_req_t r;
        expect_t  e;
        string    line;
        int       fd;
        int       n;
        int       vec;
        int       waited;
        logic     ok;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready === 1'b1) else report_mismatch("req_ready after reset", 1, req_ready);
        assert (rsp_valid === 1'b0) else report_mismatch("rsp_valid after reset", 0, rsp_valid);

        fd  = $fopen("verif/csr_input.txt", "r");
        ok  = (fd != 0);
        vec = 0;
        if (!ok) begin
            $display("could not open verif/csr_input.txt for reading");
            errors++;
        end
        while (ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && parse_vector(line, vec, r, e)) begin
                send_request(r, e, ok);
                vec++;
            end
        end
        req_valid = 1'b0;
        if (fd != 0) begin
            $fclose(fd);
        end

        waited = 0;
        while (ok && (exp_q.size() != 0 || rsp_valid) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ok && (exp_q.size() != 0 || rsp_valid)) begin
            $display("timeout: %0d results still outstanding after %0d cycles",
                     exp_q.size(), DRAIN_TIMEOUT);
            errors++;
        end else if (ok) begin
            assert (vec > 0 && delivered == vec) else begin
                $display("%0d results delivered for %0d requests", delivered, vec);
                errors++;
            end
        end
        done = 1'b1;

        $display("%0d errors, %0d results checked", errors, delivered);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- source/csr_top.sv
/*
 * Top level of the CSR block. Requests enter on a valid/ready port and
 * old register values leave on a second valid/ready port.
 */
`include "csr_cfg.svh"

module csr_top #(
    parameter int CORE_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  csr_pkg::csr_req_t    req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output csr_pkg::csr_rsp_t    rsp,
    input  logic                 rsp_ready
);

    logic [63:0]                 cycles;
    logic [63:0]                 instret;
    logic [`CSR_ADDR_BITS-1:0]   read_addr;
    logic [`WID_BITS-1:0]        read_wid;
    logic [`XLEN-1:0]            read_data;
    logic                        write_enable;
    logic [`WID_BITS-1:0]        write_wid;
    logic [`CSR_ADDR_BITS-1:0]   write_addr;
    logic [`XLEN-1:0]            write_data;
    logic                        retire;

    // A CSR instruction retires when its result is taken
    assign retire = rsp_valid && rsp_ready;

    retire_counters counters (
        .clk     (clk),
        .rst     (rst),
        .retire  (retire),
        .cycles  (cycles),
        .instret (instret)
    );

    csr_regfile regfile (
        .clk          (clk),
        .rst          (rst),
        .cycles       (cycles),
        .instret      (instret),
        .read_addr    (read_addr),
        .read_wid     (read_wid),
        .read_data    (read_data),
        .write_enable (write_enable),
        .write_wid    (write_wid),
        .write_addr   (write_addr),
        .write_data   (write_data)
    );

    csr_exec #(
        .CORE_ID (CORE_ID)
    ) exec (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready),
        .read_addr    (read_addr),
        .read_wid     (read_wid),
        .read_data    (read_data),
        .write_enable (write_enable),
        .write_wid    (write_wid),
        .write_addr   (write_addr),
        .write_data   (write_data)
    );

endmodule

//--- source/csr_exec.sv
/*
 * CSR execution unit. Decodes one request per cycle, reads the old value,
 * computes per-lane identity values and the write value, and pushes the
 * old values into a two-entry result buffer.
 */
`include "csr_cfg.svh"

module csr_exec #(
    parameter int CORE_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  csr_pkg::csr_req_t            req,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output csr_pkg::csr_rsp_t            rsp,
    input  logic                         rsp_ready,
    output logic [`CSR_ADDR_BITS-1:0]    read_addr,
    output logic [`WID_BITS-1:0]         read_wid,
    input  logic [`XLEN-1:0]             read_data,
    output logic                         write_enable,
    output logic [`WID_BITS-1:0]         write_wid,
    output logic [`CSR_ADDR_BITS-1:0]    write_addr,
    output logic [`XLEN-1:0]             write_data
);
    import csr_pkg::*;

    logic [`NUM_LANES-1:0][`XLEN-1:0] wtid;
    logic [`NUM_LANES-1:0][`XLEN-1:0] gtid;
    logic [`NUM_LANES-1:0][`XLEN-1:0] lane_data;
    logic [`XLEN-1:0]                 src;
    csr_rsp_t                         rsp_in;

    assign read_addr = req.addr;
    assign read_wid  = req.wid;

    // Each lane gets its thread id within the warp and its global hart id
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        assign wtid[i] = `XLEN'(req.pid) * `XLEN'(`NUM_LANES) + `XLEN'(i);
        assign gtid[i] = (`XLEN'(CORE_ID) << (`WID_BITS + `NT_BITS))
                       + (`XLEN'(req.wid) << `NT_BITS)
                       + wtid[i];
    end

    always_comb begin
        case (req.addr)
            `CSR_THREAD_ID: lane_data = wtid;
            `CSR_MHARTID:   lane_data = gtid;
            default:        lane_data = {`NUM_LANES{read_data}};
        endcase
    end

    // Source operand is uniform across the warp, so lane 0 supplies it
    assign src = req.use_imm ? `XLEN'(req.imm5) : req.rs1[0];

    always_comb begin
        case (req.op)
            csr_rw:  write_data = src;
            csr_rs:  write_data = read_data | src;
            default: write_data = read_data & ~src;
        endcase
    end

    // Set and clear with a zero source are pure reads
    assign write_enable = req_valid && req_ready && ((req.op == csr_rw) || (src != '0));
    assign write_wid    = req.wid;
    assign write_addr   = req.addr;

    assign rsp_in = '{wid: req.wid, pid: req.pid, data: lane_data};

    elastic_buffer #(
        .DATAW ($bits(csr_rsp_t))
    ) rsp_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (req_valid),
        .ready_in  (req_ready),
        .data_in   (rsp_in),
        .valid_out (rsp_valid),
        .data_out  (rsp),
        .ready_out (rsp_ready)
    );

endmodule

//--- source/elastic_buffer.sv
/*
 * Two-entry valid/ready buffer with a registered output stage.
 * The input side is ready while either entry is free, so ready_in never
 * depends combinationally on ready_out and full throughput is kept.
 */
module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             push;
    logic             pop;

    // The skid entry only fills while the output entry is occupied
    assign ready_in = !skid_valid;
    assign push     = valid_in && ready_in;
    assign pop      = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (pop) begin
            if (skid_valid) begin
                data_out   <= skid_data;
                skid_valid <= 1'b0;
            end else if (push) begin
                data_out <= data_in;
            end else begin
                valid_out <= 1'b0;
            end
        end else if (push) begin
            if (!valid_out) begin
                data_out  <= data_in;
                valid_out <= 1'b1;
            end else begin
                skid_data  <= data_in;
                skid_valid <= 1'b1;
            end
        end
    end

endmodule

//--- source/csr_regfile.sv
/*
 * Per-warp CSR storage with a combinational read port and one write port.
 * Holds mscratch and the floating-point status word for each warp, and
 * maps the cycle and instret counters into the read-only address space.
 */
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [63:0]                  cycles,
    input  logic [63:0]                  instret,
    input  logic [`CSR_ADDR_BITS-1:0]    read_addr,
    input  logic [`WID_BITS-1:0]         read_wid,
    output logic [`XLEN-1:0]             read_data,
    input  logic                         write_enable,
    input  logic [`WID_BITS-1:0]         write_wid,
    input  logic [`CSR_ADDR_BITS-1:0]    write_addr,
    input  logic [`XLEN-1:0]             write_data
);
    import csr_pkg::*;

    logic [`XLEN-1:0] mscratch [`NUM_WARPS];
    fcsr_u            fcsr     [`NUM_WARPS];

    // Unknown addresses read as zero
    always_comb begin
        case (read_addr)
            `CSR_FFLAGS: begin
                read_data = `XLEN'(fcsr[read_wid].field.fflags);
            end
            `CSR_FRM: begin
                read_data = `XLEN'(fcsr[read_wid].field.frm);
            end
            `CSR_FCSR: begin
                read_data = `XLEN'(fcsr[read_wid].word);
            end
            `CSR_MSCRATCH: begin
                read_data = mscratch[read_wid];
            end
            `CSR_CYCLE: begin
                read_data = cycles[`XLEN-1:0];
            end
            `CSR_INSTRET: begin
                read_data = instret[`XLEN-1:0];
            end
            default: begin
                read_data = '0;
            end
        endcase
    end

    // Write side. The counters and unknown addresses drop the write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                mscratch[w]  <= '0;
                fcsr[w].word <= '0;
            end
        end else if (write_enable) begin
            case (write_addr)
                `CSR_FFLAGS: begin
                    fcsr[write_wid].field.fflags <= write_data[4:0];
                end
                `CSR_FRM: begin
                    fcsr[write_wid].field.frm <= write_data[2:0];
                end
                `CSR_FCSR: begin
                    fcsr[write_wid].word <= write_data[7:0];
                end
                `CSR_MSCRATCH: begin
                    mscratch[write_wid] <= write_data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/retire_counters.sv
/*
 * Free-running cycle counter and a counter of delivered CSR results.
 * Both are 64 bits wide and clear on reset.
 */
module retire_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        retire,
    output logic [63:0] cycles,
    output logic [63:0] instret
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycles  <= 64'd0;
            instret <= 64'd0;
        end else begin
            cycles <= cycles + 64'd1;
            // One pulse per result handed to the consumer
            if (retire) begin
                instret <= instret + 64'd1;
            end
        end
    end

endmodule

//--- source/csr_pkg.sv
/*
 * Shared types of the CSR execution block: operation codes, the request
 * and result words, and the floating-point status word with its fields.
 */
`include "csr_cfg.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        csr_rw = 2'd0,
        csr_rs = 2'd1,
        csr_rc = 2'd2
    } csr_op_e;

    // Rounding mode sits above the accrued exception flags, as in fcsr
    typedef struct packed {
        logic [2:0] frm;
        logic [4:0] fflags;
    } fcsr_fields_t;

    typedef union packed {
        logic [7:0]   word;
        fcsr_fields_t field;
    } fcsr_u;

    // One CSR instruction for a thread group of a warp
    typedef struct packed {
        logic [`WID_BITS-1:0]                wid;
        logic [`PID_BITS-1:0]                pid;
        csr_op_e                             op;
        logic [`CSR_ADDR_BITS-1:0]           addr;
        logic                                use_imm;
        logic [4:0]                          imm5;
        logic [`NUM_LANES-1:0][`XLEN-1:0]    rs1;
    } csr_req_t;

    // Old register value returned for every lane
    typedef struct packed {
        logic [`WID_BITS-1:0]                wid;
        logic [`PID_BITS-1:0]                pid;
        logic [`NUM_LANES-1:0][`XLEN-1:0]    data;
    } csr_rsp_t;

endpackage

//--- source/csr_cfg.svh
/*
 * Build-time sizes and CSR address map for the CSR execution block.
 * Include this header wherever a width, a count or an address is needed.
 */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define XLEN            32
`define NUM_LANES       4
`define NUM_THREADS     8
`define NUM_WARPS       4
`define CSR_ADDR_BITS   12

// Derived index widths
`define WID_BITS        $clog2(`NUM_WARPS)
`define NT_BITS         $clog2(`NUM_THREADS)
`define PID_BITS        $clog2(`NUM_THREADS / `NUM_LANES)

`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003
`define CSR_MSCRATCH    12'h340
`define CSR_CYCLE       12'hC00
`define CSR_INSTRET     12'hC02
`define CSR_THREAD_ID   12'hCC0
`define CSR_MHARTID     12'hF14

`endif
